/* tb.f */
+incdir+rtl
rtl/mipsPkg.sv
rtl/ctrlDecoder.sv
rtl/decodeStage.sv
rtl/stageReg.sv
rtl/executeStage.sv
rtl/mipsCore.sv
tests/mipsCore_checker.sv
tests/tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tb -Mdir obj_dir -o simTb

# Assertion failures must not stop the model before the closing line
./obj_dir/simTb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation ended without a closing line"
	exit 1
fi

/* tests/tb.sv */
module tb;

	localparam int romWords = 48;
	localparam int timeoutLimit = (10 + 3 * romWords + 20) * 100;
	localparam logic [31:0] selfJumpPc = 32'd184;   // Word 46

	logic        clk;
	logic        rstN;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        wbValid;
	logic [4:0]  wbReg;
	logic [31:0] wbData;
	logic        memWriteEn;
	logic [31:0] memAddr;
	logic [31:0] memWData;

	logic [31:0] rom [romWords];
	int seed = 37;
	int wbCount = 0;
	int storeCount = 0;
	int otherErrors = 0;

	mipsCore dut0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.memWriteEn(memWriteEn),
		.memAddr(memAddr),
		.memWData(memWData)
	);

	bind mipsCore mipsCore_checker chk0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.memWriteEn(memWriteEn),
		.memAddr(memAddr),
		.memWData(memWData)
	);

	always #50 clk = ~clk;

	//////////////////////////////
	// Instruction encoding
	//////////////////////////////

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] func);
		return {6'b000000, rs, rt, rd, 5'd0, func};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	// Keeps r2 as the store base and r3 nonzero for beq
	function automatic logic [4:0] pickReg(input logic [2:0] v);
		return (v == 3'd2 || v == 3'd3) ? 5'd0 : {2'b00, v};
	endfunction

	function automatic logic [31:0] randomAlu(input int kind, input logic [31:0] r);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] d;
		rs = {2'b00, r[5:3]};
		rt = {2'b00, r[8:6]};
		d  = pickReg(r[11:9]);
		case (kind)
			0: return encodeR(rs, rt, d, 6'b100000);          // add
			1: return encodeR(rs, rt, d, 6'b100010);          // sub
			2: return encodeI(6'b001101, rs, d, r[31:16]);    // ori
			3: return encodeI(6'b001111, 5'd0, d, r[31:16]);  // lui
			default: return encodeI(6'b001000, rs, d, r[31:16]);   // lrm
		endcase
	endfunction

	task automatic buildProgram();
		logic [31:0] r;
		logic [15:0] off;
		logic [15:0] lastOff;
		int base;
		lastOff = 16'd0;
		for (int i = 0; i < romWords; i++)
			rom[i] = 32'd0;   // Unknown function code retires as a no-op
		// Prologue sets r1 to r7
		rom[0] = encodeI(6'b001111, 5'd0, 5'd1, 16'h1234);
		rom[1] = encodeI(6'b001101, 5'd0, 5'd2, 16'h0040);
		for (int i = 3; i <= 7; i++) begin
			r = $random(seed);
			rom[i - 1] = encodeI(6'b001101, 5'd0, i[4:0], r[15:0] | 16'h0001);
		end
		rom[7] = encodeI(6'b001101, 5'd0, 5'd0, 16'h0005);   // Dropped r0 write
		// ALU, store and load groups each followed by a no-op
		for (int g = 0; g < 6; g++) begin
			base = 8 + 4 * g;
			r = $random(seed);
			rom[base] = randomAlu(g % 5, r);
			rom[base + 1] = g[0] ? 32'hFC00_0000 : 32'd0;   // Unknown opcode
			r = $random(seed);
			off = {8'd0, r[7:2], 2'b00};
			if (g[0] == 1'b0) begin
				rom[base + 2] = encodeI(6'b101011, 5'd2, pickReg(r[10:8]), off);
				lastOff = off;
			end else begin
				rom[base + 2] = encodeI(6'b100011, 5'd2, pickReg(r[10:8]), lastOff);
			end
		end
		// Control flow
		rom[32] = encodeI(6'b000100, 5'd3, 5'd3, 16'd2);     // Taken to 35
		rom[33] = encodeI(6'b001101, 5'd0, 5'd5, 16'h0BAD);  // Skipped
		rom[35] = encodeI(6'b000100, 5'd3, 5'd0, 16'd5);     // Not taken
		rom[36] = encodeJ(6'b000011, 26'd40);                // jal
		rom[37] = encodeJ(6'b000010, 26'd44);                // jr lands here
		rom[38] = 32'hFC00_0000;
		rom[41] = encodeR(5'd31, 5'd0, 5'd0, 6'b001000);     // jr r31
		rom[44] = encodeI(6'b001101, 5'd0, 5'd7, 16'h0077);
		rom[46] = encodeJ(6'b000010, 26'd46);                // Self-jump
	endtask

	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		if (addr < 32'(romWords * 4))
			return rom[addr[7:2]];
		return 32'd0;
	endfunction

	// Fetch a little after the edge
	always @(posedge clk) begin
		#10;
		instr = fetchWord(pc);
	end

	always @(negedge clk) begin
		if (rstN && wbValid)
			wbCount++;
		if (rstN && memWriteEn)
			storeCount++;
	end

	initial begin
		#(timeoutLimit);
		$display("Timeout, pc never reached the final self-jump");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instr = 32'd0;
		buildProgram();
		repeat (10) @(posedge clk);
		#10;
		rstN = 1'b1;
		while (pc != selfJumpPc)
			@(posedge clk);
		repeat (4) @(posedge clk);   // Drain both buffers
		#10;
		if (wbCount == 0 || storeCount == 0) begin
			$display("No write-back or store was seen, the program did not run");
			otherErrors++;
		end
		$display("Errors: %0d assertion, %0d other; %0d write-backs, %0d stores",
			dut0.chk0.errorCount, otherErrors, wbCount, storeCount);
		if (dut0.chk0.errorCount == 0 && otherErrors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* tests/mipsCore_checker.sv */
`include "mips_macros.svh"

module mipsCore_checker (
	input logic        clk,
	input logic        rstN,
	input logic [31:0] instr,
	input logic [31:0] pc,
	input logic        wbValid,
	input logic [4:0]  wbReg,
	input logic [31:0] wbData,
	input logic        memWriteEn,
	input logic [31:0] memAddr,
	input logic [31:0] memWData
);

	localparam int idxW = $clog2(`DMEM_WORDS);

	int errorCount = 0;

	logic [31:0] shadowReg [`REG_COUNT];
	logic [31:0] shadowMem [`DMEM_WORDS];
	logic        memKnown [`DMEM_WORDS];   // Word stored at least once

	// Expectation for the word in decode
	logic [31:0] rsV, rtV, sImm, zImm, pc4;
	logic        dWe, dLw, dSw;
	logic [4:0]  dDest;
	logic [31:0] dData, dAddr, dNext;

	// s1 lines up with execute, s2 with write-back
	logic        s1Valid, s1We, s1Lw, s1Sw, s2We, s2Chk;
	logic [4:0]  s1Dest, s2Dest;
	logic [31:0] s1Data, s1Addr, s1SwData, s1Next, s2Data;

	function automatic logic [31:0] regRead(input logic [4:0] r);
		if (r == 5'd0)
			return 32'd0;
		if (wbValid && wbReg == r)
			return wbData;   // Same-cycle write seen by decode
		return shadowReg[r];
	endfunction

	function automatic logic [idxW-1:0] memIndex(input logic [31:0] a);
		return a[idxW+1:2];
	endfunction

	//////////////////////////////
	// Reference model of decode
	//////////////////////////////

	always_comb begin
		rsV   = regRead(instr[25:21]);
		rtV   = regRead(instr[20:16]);
		sImm  = {{16{instr[15]}}, instr[15:0]};
		zImm  = {16'd0, instr[15:0]};
		pc4   = pc + 32'd4;
		dWe   = 1'b0;
		dLw   = 1'b0;
		dSw   = 1'b0;
		dDest = instr[20:16];   // rt unless noted
		dData = 32'd0;
		dAddr = rsV + sImm;
		dNext = pc4;
		case (instr[31:26])
			6'b000000: begin
				if (instr[5:0] == 6'b100000 || instr[5:0] == 6'b100010) begin
					dWe   = 1'b1;
					dDest = instr[15:11];
					dData = (instr[5:0] == 6'b100010) ? rsV - rtV : rsV + rtV;
				end else if (instr[5:0] == 6'b001000) begin
					dNext = rsV;   // jr
				end
			end
			6'b001101: begin
				dWe   = 1'b1;
				dData = rsV | zImm;
			end
			6'b100011: begin
				dWe = 1'b1;
				dLw = 1'b1;
			end
			6'b101011: dSw = 1'b1;
			6'b000100: begin
				if (rsV == rtV)
					dNext = pc4 + {sImm[29:0], 2'b00};
			end
			6'b001111: begin
				dWe   = 1'b1;
				dData = {instr[15:0], 16'd0};
			end
			6'b000010: dNext = {pc4[31:28], instr[25:0], 2'b00};
			6'b000011: begin
				dWe   = 1'b1;
				dDest = `LINK_REG;
				dData = pc4;
				dNext = {pc4[31:28], instr[25:0], 2'b00};
			end
			6'b001000: begin
				dWe   = 1'b1;
				dData = dAddr;   // lrm returns the address itself
			end
			default: ;   // Unknown encodings retire silently
		endcase
		if (dDest == 5'd0)
			dWe = 1'b0;   // r0 writes dropped
	end

	//////////////////////////////
	// History and shadow state
	//////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			s1We    <= 1'b0;
			s1Lw    <= 1'b0;
			s1Sw    <= 1'b0;
			s2We    <= 1'b0;
			s2Chk   <= 1'b0;
			for (int i = 0; i < `REG_COUNT; i++)
				shadowReg[i] <= 32'd0;
			for (int i = 0; i < `DMEM_WORDS; i++)
				memKnown[i] <= 1'b0;
		end else begin
			s1Valid  <= 1'b1;
			s1We     <= dWe;
			s1Lw     <= dLw;
			s1Sw     <= dSw;
			s1Dest   <= dDest;
			s1Data   <= dData;
			s1Addr   <= dAddr;
			s1SwData <= rtV;
			s1Next   <= dNext;
			s2We     <= s1We;
			s2Dest   <= s1Dest;
			// Load value taken in its execute cycle
			s2Chk    <= !s1Lw || memKnown[memIndex(s1Addr)];
			s2Data   <= s1Lw ? shadowMem[memIndex(s1Addr)] : s1Data;
			if (wbValid && wbReg != 5'd0)
				shadowReg[wbReg] <= wbData;
			if (memWriteEn) begin
				shadowMem[memIndex(memAddr)] <= memWData;
				memKnown[memIndex(memAddr)]  <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////

	assert property (@(posedge clk) !rstN |=> (pc == `RESET_PC && !wbValid && !memWriteEn))
		else begin
			errorCount++;
			$error("Fail t=%0t pc/wbValid/memWriteEn got %h/%b/%b expected %h/0/0",
				$time, $sampled(pc), $sampled(wbValid), $sampled(memWriteEn),
				`RESET_PC);
		end

	assert property (@(posedge clk) disable iff (!rstN) wbValid == s2We)
		else begin
			errorCount++;
			$error("Fail t=%0t wbValid got %b expected %b", $time, $sampled(wbValid),
				$sampled(s2We));
		end

	assert property (@(posedge clk) disable iff (!rstN) s2We |-> wbReg == s2Dest)
		else begin
			errorCount++;
			$error("Fail t=%0t wbReg got %0d expected %0d", $time, $sampled(wbReg),
				$sampled(s2Dest));
		end

	assert property (@(posedge clk) disable iff (!rstN) s2We && s2Chk |-> wbData == s2Data)
		else begin
			errorCount++;
			$error("Fail t=%0t wbData got %h expected %h", $time, $sampled(wbData),
				$sampled(s2Data));
		end

	assert property (@(posedge clk) disable iff (!rstN) memWriteEn == s1Sw)
		else begin
			errorCount++;
			$error("Fail t=%0t memWriteEn got %b expected %b", $time, $sampled(memWriteEn),
				$sampled(s1Sw));
		end

	assert property (@(posedge clk) disable iff (!rstN) s1Sw |-> memAddr == s1Addr)
		else begin
			errorCount++;
			$error("Fail t=%0t memAddr got %h expected %h", $time, $sampled(memAddr),
				$sampled(s1Addr));
		end

	assert property (@(posedge clk) disable iff (!rstN) s1Sw |-> memWData == s1SwData)
		else begin
			errorCount++;
			$error("Fail t=%0t memWData got %h expected %h", $time, $sampled(memWData),
				$sampled(s1SwData));
		end

	assert property (@(posedge clk) disable iff (!rstN) s1Valid |-> pc == s1Next)
		else begin
			errorCount++;
			$error("Fail t=%0t pc got %h expected %h", $time, $sampled(pc),
				$sampled(s1Next));
		end

endmodule

/* rtl/mipsCore.sv */
module mipsCore (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] instr,
	output logic [31:0] pc,
	output logic        wbValid,
	output logic [4:0]  wbReg,
	output logic [31:0] wbData,
	output logic        memWriteEn,
	output logic [31:0] memAddr,
	output logic [31:0] memWData
);

	mipsPkg::deType deIn, deOut;
	mipsPkg::ewType ewIn, ewOut;

	//////////////////////////////
	// Decode and fetch
	//////////////////////////////

	decodeStage dec0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.deIn(deIn),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	stageReg #(.payloadT(mipsPkg::deType)) deBuf (
		.clk(clk),
		.rstN(rstN),
		.dIn(deIn),
		.dOut(deOut)
	);

	//////////////////////////////
	// Execute and write-back
	//////////////////////////////

	executeStage exe0 (
		.clk(clk),
		.rstN(rstN),
		.deOut(deOut),
		.ewIn(ewIn),
		.memWriteEn(memWriteEn),
		.memAddr(memAddr),
		.memWData(memWData)
	);

	stageReg #(.payloadT(mipsPkg::ewType)) ewBuf (
		.clk(clk),
		.rstN(rstN),
		.dIn(ewIn),
		.dOut(ewOut)
	);

	// Register write port back into decode
	assign wbValid = ewOut.valid & ewOut.regWrite;
	assign wbReg   = ewOut.destReg;
	assign wbData  = ewOut.wbData;

endmodule

/* rtl/executeStage.sv */
`include "mips_macros.svh"

module executeStage (
	input  logic           clk,
	input  logic           rstN,
	input  mipsPkg::deType deOut,
	output mipsPkg::ewType ewIn,
	output logic           memWriteEn,
	output logic [31:0]    memAddr,
	output logic [31:0]    memWData
);

	localparam int IdxW = $clog2(`DMEM_WORDS);

	logic [31:0] dataMem [`DMEM_WORDS];

	logic [31:0] aluB, aluRes, effAddr, memRData;
	logic [IdxW-1:0] memIdx;

	//////////////////////////////
	// ALU
	//////////////////////////////

	assign aluB = deOut.aluSrcImm ? deOut.extImm : deOut.rtVal;

	always_comb begin
		case (deOut.aluOp)
			mipsPkg::aluSub: aluRes = deOut.rsVal - aluB;
			mipsPkg::aluOr:  aluRes = deOut.rsVal | aluB;
			mipsPkg::aluLui: aluRes = {aluB[15:0], 16'd0};
			default:         aluRes = deOut.rsVal + aluB;
		endcase
	end

	// rs plus sign-extended offset, for sw, lw and lrm
	assign effAddr = deOut.rsVal + deOut.extImm;

	//////////////////////////////
	// Data memory
	//////////////////////////////

	assign memWriteEn = deOut.valid & deOut.memWrite;
	assign memAddr    = effAddr;
	assign memWData   = deOut.rtVal;
	assign memIdx     = memAddr[IdxW+1:2];   // Word addressed

	always_ff @(posedge clk) begin
		if (memWriteEn && rstN)   // No stores while held in reset
			dataMem[memIdx] <= memWData;
	end

	assign memRData = dataMem[memIdx];   // Async read

	// Write-back select and payload
	always_comb begin
		ewIn.valid    = deOut.valid & deOut.regWrite & (deOut.destReg != 5'd0);
		ewIn.regWrite = deOut.regWrite;
		ewIn.destReg  = deOut.destReg;
		case (deOut.wbSel)
			mipsPkg::wbMem:  ewIn.wbData = memRData;
			mipsPkg::wbLink: ewIn.wbData = deOut.linkPc;
			mipsPkg::wbEa:   ewIn.wbData = effAddr;
			default:         ewIn.wbData = aluRes;
		endcase
	end

endmodule

/* rtl/stageReg.sv */
module stageReg #(
	parameter type payloadT = logic   // Struct carried between stages
) (
	input  logic    clk,
	input  logic    rstN,
	input  payloadT dIn,
	output payloadT dOut
);

	//////////////////////////////
	// Pipeline register
	//////////////////////////////

	// All-zero payload has valid low, so an empty slot after reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			dOut <= '0;
		else
			dOut <= dIn;   // Advances every cycle without stalling
	end

endmodule

/* rtl/decodeStage.sv */
`include "mips_macros.svh"

module decodeStage (
	input  logic           clk,
	input  logic           rstN,
	input  logic [31:0]    instr,
	output logic [31:0]    pc,
	output mipsPkg::deType deIn,
	input  logic           wbValid,  // Write-back port from ewBuf
	input  logic [4:0]     wbReg,
	input  logic [31:0]    wbData
);

	logic [31:0] regFile [`REG_COUNT];

	logic [4:0]  rs, rt, rd;
	logic [15:0] imm;
	logic [31:0] rsVal, rtVal, extImm;
	logic [31:0] pcPlus4, branchOff, nextPc;
	logic        branchTaken;

	mipsPkg::regDstT regDst;
	mipsPkg::aluOpT  aluOp;
	mipsPkg::wbSelT  wbSel;
	mipsPkg::npcOpT  npcOp;
	logic regWrite, extSigned, aluSrcImm, memWrite, isBranch;

	assign rs  = instr[25:21];
	assign rt  = instr[20:16];
	assign rd  = instr[15:11];
	assign imm = instr[15:0];

	ctrlDecoder ctrl0 (
		.op(instr[31:26]),
		.func(instr[5:0]),
		.regDst(regDst),
		.regWrite(regWrite),
		.extSigned(extSigned),
		.aluSrcImm(aluSrcImm),
		.aluOp(aluOp),
		.memWrite(memWrite),
		.wbSel(wbSel),
		.npcOp(npcOp),
		.isBranch(isBranch)
	);

	//////////////////////////////
	// Register file
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (wbValid && wbReg != 5'd0)
			regFile[wbReg] <= wbData;   // r0 never written
	end

	// Write-through so a write-back this cycle is seen by decode
	assign rsVal = (rs == 5'd0) ? 32'd0 :
		(wbValid && wbReg == rs) ? wbData : regFile[rs];
	assign rtVal = (rt == 5'd0) ? 32'd0 :
		(wbValid && wbReg == rt) ? wbData : regFile[rt];

	assign extImm = extSigned ? {{16{imm[15]}}, imm} : {16'd0, imm};

	//////////////////////////////
	// Next PC
	//////////////////////////////

	assign pcPlus4     = pc + 32'd4;
	assign branchOff   = {{14{imm[15]}}, imm, 2'b00};   // Always signed for beq
	assign branchTaken = isBranch && (rsVal == rtVal);

	always_comb begin
		case (npcOp)
			mipsPkg::npcJump:   nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
			mipsPkg::npcBranch: nextPc = branchTaken ? pcPlus4 + branchOff : pcPlus4;
			mipsPkg::npcReg:    nextPc = rsVal;
			default:            nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= `RESET_PC;
		else
			pc <= nextPc;   // No bubble on taken jumps
	end

	// Payload toward execute
	always_comb begin
		deIn.valid     = regWrite | memWrite;   // Anything else retires here
		deIn.aluOp     = aluOp;
		deIn.aluSrcImm = aluSrcImm;
		deIn.memWrite  = memWrite;
		deIn.wbSel     = wbSel;
		deIn.regWrite  = regWrite;
		case (regDst)
			mipsPkg::dstRd:   deIn.destReg = rd;
			mipsPkg::dstLink: deIn.destReg = `LINK_REG;
			default:          deIn.destReg = rt;
		endcase
		deIn.rsVal  = rsVal;
		deIn.rtVal  = rtVal;
		deIn.extImm = extImm;
		deIn.linkPc = pcPlus4;
	end

endmodule

/* rtl/ctrlDecoder.sv */
module ctrlDecoder (
	input  logic [5:0]       op,
	input  logic [5:0]       func,
	output mipsPkg::regDstT  regDst,
	output logic             regWrite,
	output logic             extSigned,  // Sign extend the immediate
	output logic             aluSrcImm,  // ALU operand B from immediate
	output mipsPkg::aluOpT   aluOp,
	output logic             memWrite,
	output mipsPkg::wbSelT   wbSel,
	output mipsPkg::npcOpT   npcOp,
	output logic             isBranch
);

	logic rType;
	logic isAdd, isSub, isJr;
	logic isOri, isLw, isSw, isBeq, isLui, isJ, isJal, isLrm;

	//////////////////////////////
	// Instruction recognition
	//////////////////////////////

	assign rType = (op == 6'b000000);

	// Special opcode split by function field
	assign isAdd = rType & (func == 6'b100000);
	assign isSub = rType & (func == 6'b100010);
	assign isJr  = rType & (func == 6'b001000);

	assign isOri = (op == 6'b001101);
	assign isLw  = (op == 6'b100011);
	assign isSw  = (op == 6'b101011);
	assign isBeq = (op == 6'b000100);
	assign isLui = (op == 6'b001111);
	assign isJ   = (op == 6'b000010);
	assign isJal = (op == 6'b000011);
	assign isLrm = (op == 6'b001000);   // Address-forming load

	//////////////////////////////
	// Control lines
	//////////////////////////////

	assign regDst = isJal ? mipsPkg::dstLink :
		(isAdd | isSub) ? mipsPkg::dstRd : mipsPkg::dstRt;

	assign regWrite = isAdd | isSub | isOri | isLw | isLui | isJal | isLrm;

	// ori and lui stay zero-extended
	assign extSigned = isLw | isSw | isLrm;

	assign aluSrcImm = isOri | isLw | isSw | isLui | isLrm;

	assign aluOp = isLui ? mipsPkg::aluLui :
		isOri ? mipsPkg::aluOr :
		isSub ? mipsPkg::aluSub : mipsPkg::aluAdd;

	assign memWrite = isSw;

	assign wbSel = isLrm ? mipsPkg::wbEa :
		isJal ? mipsPkg::wbLink :
		isLw ? mipsPkg::wbMem : mipsPkg::wbAlu;

	// Unknown encodings fall through to sequential
	assign npcOp = isJr ? mipsPkg::npcReg :
		isBeq ? mipsPkg::npcBranch :
		(isJ | isJal) ? mipsPkg::npcJump : mipsPkg::npcSeq;

	assign isBranch = isBeq;

endmodule

/* rtl/mipsPkg.sv */
package mipsPkg;

	//////////////////////////////
	// Control encodings
	//////////////////////////////

	typedef enum logic [1:0] {
		aluAdd = 2'd0,   // Also used for lw, sw, lrm
		aluSub = 2'd1,
		aluOr  = 2'd2,   // ori
		aluLui = 2'd3    // Immediate into upper half
	} aluOpT;

	typedef enum logic [1:0] {
		dstRt   = 2'd0,  // I-type
		dstRd   = 2'd1,  // R-type
		dstLink = 2'd2   // jal
	} regDstT;

	typedef enum logic [1:0] {
		wbAlu  = 2'd0,
		wbMem  = 2'd1,   // Load data
		wbLink = 2'd2,   // PC+4 for jal
		wbEa   = 2'd3    // Effective address for lrm
	} wbSelT;

	typedef enum logic [1:0] {
		npcSeq    = 2'd0,
		npcJump   = 2'd1, // j, jal
		npcBranch = 2'd2, // beq
		npcReg    = 2'd3  // jr
	} npcOpT;

	//////////////////////////////
	// Pipeline payloads
	//////////////////////////////

	// Decode to execute
	typedef struct packed {
		logic        valid;     // Slot has a downstream effect
		aluOpT       aluOp;
		logic        aluSrcImm;
		logic        memWrite;
		wbSelT       wbSel;
		logic        regWrite;
		logic [4:0]  destReg;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] extImm;
		logic [31:0] linkPc;
	} deType;

	// Execute to write-back
	typedef struct packed {
		logic        valid;     // Write to a nonzero register
		logic        regWrite;
		logic [4:0]  destReg;
		logic [31:0] wbData;
	} ewType;

endpackage

/* rtl/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Register file depth with r0 hardwired to zero
`define REG_COUNT 32

// Data memory depth in 32-bit words
`define DMEM_WORDS 64

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Return address register written by jal
`define LINK_REG 5'd31

`endif
